// File: rtl/ep_mem_pkg.sv
//-----------------------------
// Endpoint memory access types
// Word, lane and enable widths plus
// the write controller state encoding
//-----------------------------

package ep_mem_pkg;

    // Data words and lanes
    typedef logic [31:0] dword_t;     // Register or payload word
    typedef logic [7:0]  byte_t;      // One byte lane
    typedef logic [3:0]  be_t;        // One enable per lane

    // Register index space
    typedef logic [6:0]  reg_addr_t;  // Dword index

    localparam int NUM_LANES = 4;     // Lanes per dword

    //-----------------------------
    // Read-modify-write sequencing
    //-----------------------------
    typedef enum logic [1:0] {
        IDLE  = 2'd0,                 // Waiting for a write strobe
        READ  = 2'd1,                 // Capture old word
        WRITE = 2'd2                  // Commit merged word
    } wr_state_t;

endpackage

// File: rtl/ep_regmap_pkg.sv
//-----------------------------
// Endpoint control register map
// Dword indices and field positions
//-----------------------------

package ep_regmap_pkg;

    import ep_mem_pkg::*;

    // Writable control words
    localparam reg_addr_t REG_CTRL       = 7'd0;   // Initiator reset
    localparam reg_addr_t REG_DMA_CMD    = 7'd1;   // DMA start and done
    localparam reg_addr_t REG_MWR_ADDR   = 7'd2;
    localparam reg_addr_t REG_MWR_COUNT  = 7'd3;
    localparam reg_addr_t REG_MWR_DATA   = 7'd4;
    localparam reg_addr_t REG_ACQ_TIME   = 7'd5;
    localparam reg_addr_t REG_ACQ_COUNT  = 7'd6;
    localparam reg_addr_t REG_ACQ_PARAM0 = 7'd7;
    localparam reg_addr_t REG_ACQ_PARAM1 = 7'd8;
    localparam reg_addr_t REG_ACQ_CTRL   = 7'd9;   // Stop mode and triggers

    // Status words, read only
    localparam reg_addr_t REG_LIST_CNT   = 7'd10;
    localparam reg_addr_t REG_LINK_STAT  = 7'd11;

    //-----------------------------
    // Field positions
    //-----------------------------
    localparam int INIT_RST_BIT  = 0;  // In REG_CTRL
    localparam int DMA_START_BIT = 0;  // In REG_DMA_CMD
    localparam int DMA_DONE_BIT  = 8;  // Read-only flag in REG_DMA_CMD
    localparam int ACQ_START_BIT = 4;  // Trigger that reads as zero
    localparam int ACQ_STOP_BIT  = 5;
    localparam int ACQ_INIT_BIT  = 6;
    localparam int LINK_ON_BIT   = 0;  // In REG_LINK_STAT

    typedef logic [1:0] stop_mode_t;   // REG_ACQ_CTRL bits 1:0

endpackage

// File: rtl/reg_bus_if.sv
//-----------------------------
// Internal register bus
// Carries index, write strobe and words
// in storage order between the access
// controller and the register file
//-----------------------------

`timescale 1ns/1ps

interface reg_bus_if import ep_mem_pkg::*; ();

    reg_addr_t addr;     // Register index
    logic      wr_en;    // Word written at rising edge
    dword_t    wr_data;  // Storage order with byte 0 lowest
    dword_t    rd_data;  // Combinational from addr

    modport ctrl (
        output addr,
        output wr_en,
        output wr_data,
        input  rd_data
    );

    modport regs (
        input  addr,
        input  wr_en,
        input  wr_data,
        output rd_data
    );

endinterface

// File: rtl/mem_rmw_ctrl.sv
//-----------------------------
// Byte-lane read-modify-write controller
// Latches a write, reads the old word, merges
// enabled payload bytes and commits. Reads are
// returned in payload order with lane masking
//-----------------------------

`timescale 1ns/1ps

module mem_rmw_ctrl import ep_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t addr_i,
    input  be_t       rd_be_i,
    input  be_t       wr_be_i,
    input  dword_t    wr_data_i,
    input  logic      wr_en_i,
    output dword_t    rd_data_o,
    output logic      wr_busy_o,
    reg_bus_if.ctrl   bus
);

    wr_state_t state;

    reg_addr_t addr_q;    // Latched at issue edge
    dword_t    wdata_q;   // Payload order
    be_t       wbe_q;
    dword_t    old_q;     // Storage order
    dword_t    merged;

    //-----------------------------
    // Write sequencing
    //-----------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_en_i) begin
                        state <= READ;
                    end
                end
                READ:    state <= WRITE;
                WRITE:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Request and old word
    always_ff @(posedge clk) begin
        if (state == IDLE && wr_en_i) begin
            addr_q  <= addr_i;
            wdata_q <= wr_data_i;
            wbe_q   <= wr_be_i;
        end
        if (state == READ) begin
            old_q <= bus.rd_data;           // Word at latched index
        end
    end

    // Payload byte 0 sits in bits 31:24
    always_comb begin
        byte_t new_b;
        byte_t old_b;
        merged = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            new_b = wdata_q[8*(NUM_LANES-1-i) +: 8];
            old_b = old_q[8*i +: 8];
            merged[8*i +: 8] = wbe_q[i] ? new_b : old_b;
        end
    end

    assign bus.addr    = (state == IDLE) ? addr_i : addr_q;
    assign bus.wr_en   = (state == WRITE);
    assign bus.wr_data = merged;

    assign wr_busy_o = wr_en_i | (state != IDLE);  // Covers commit cycle

    //-----------------------------
    // Read path
    //-----------------------------
    always_comb begin
        byte_t lane_b;
        rd_data_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_b = rd_be_i[i] ? bus.rd_data[8*i +: 8] : 8'h00;
            rd_data_o[8*(NUM_LANES-1-i) +: 8] = lane_b;  // Back to payload order
        end
    end

    // A commit goes to the index requested two edges earlier
    a_commit_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.wr_en |-> $past(wr_en_i, 2) && (bus.addr == $past(addr_i, 2))
    );

    // Enabled payload byte 0 lands in storage lane 0
    a_commit_lane0: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bus.wr_en && $past(wr_be_i[0], 2)) |-> (bus.wr_data[7:0] == $past(wr_data_i[31:24], 2))
    );

endmodule

// File: rtl/ep_ctrl_regs.sv
//-----------------------------
// DMA and acquisition control registers
// Decodes bus writes, drives control levels,
// acquisition pulses and the DMA done flag
//-----------------------------

`timescale 1ns/1ps

module ep_ctrl_regs import ep_mem_pkg::*, ep_regmap_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    reg_bus_if.regs    bus,
    input  logic       mwr_done_i,
    input  logic       link_on_i,
    input  dword_t     listdata_cnt_i,
    output logic       init_rst_o,
    output logic       mwr_start_o,
    output dword_t     mwr_addr_o,
    output dword_t     mwr_count_o,
    output dword_t     mwr_data_o,
    output dword_t     acq_time_o,
    output dword_t     acq_count_o,
    output dword_t     acq_param_dw0_o,
    output dword_t     acq_param_dw1_o,
    output stop_mode_t stop_mode_o,
    output logic       acq_start_o,
    output logic       acq_stop_o,
    output logic       acq_init_o
);

    logic       mwr_done_q;      // Latched until next start
    logic [2:0] acq_pulse_q;     // Init, stop, start
    logic       cmd_wr;
    logic       acq_wr;

    assign cmd_wr = bus.wr_en && (bus.addr == REG_DMA_CMD);
    assign acq_wr = bus.wr_en && (bus.addr == REG_ACQ_CTRL);

    //-----------------------------
    // Word registers
    //-----------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_o      <= 1'b0;
            mwr_addr_o      <= '0;
            mwr_count_o     <= '0;
            mwr_data_o      <= '0;
            acq_time_o      <= '0;
            acq_count_o     <= '0;
            acq_param_dw0_o <= '0;
            acq_param_dw1_o <= '0;
            stop_mode_o     <= '0;
        end else if (bus.wr_en) begin
            case (bus.addr)
                REG_CTRL:       init_rst_o      <= bus.wr_data[INIT_RST_BIT];
                REG_MWR_ADDR:   mwr_addr_o      <= bus.wr_data;
                REG_MWR_COUNT:  mwr_count_o     <= bus.wr_data;
                REG_MWR_DATA:   mwr_data_o      <= bus.wr_data;
                REG_ACQ_TIME:   acq_time_o      <= bus.wr_data;
                REG_ACQ_COUNT:  acq_count_o     <= bus.wr_data;
                REG_ACQ_PARAM0: acq_param_dw0_o <= bus.wr_data;
                REG_ACQ_PARAM1: acq_param_dw1_o <= bus.wr_data;
                REG_ACQ_CTRL:   stop_mode_o     <= stop_mode_t'(bus.wr_data[1:0]);
                default: ;                                   // Read only or unmapped
            endcase
        end
    end

    // A commit beats mwr_done_i
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mwr_start_o <= 1'b0;
            mwr_done_q  <= 1'b0;
        end else if (cmd_wr) begin
            mwr_start_o <= bus.wr_data[DMA_START_BIT];
            if (bus.wr_data[DMA_START_BIT]) begin
                mwr_done_q <= 1'b0;
            end
        end else if (mwr_done_i) begin
            mwr_start_o <= 1'b0;
            mwr_done_q  <= 1'b1;
        end
    end

    // Trigger bits only reach here with lane 0 enabled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acq_pulse_q <= '0;
        end else begin
            acq_pulse_q[0] <= acq_wr && bus.wr_data[ACQ_START_BIT];
            acq_pulse_q[1] <= acq_wr && bus.wr_data[ACQ_STOP_BIT];
            acq_pulse_q[2] <= acq_wr && bus.wr_data[ACQ_INIT_BIT];
        end
    end

    assign acq_start_o = acq_pulse_q[0];
    assign acq_stop_o  = acq_pulse_q[1];
    assign acq_init_o  = acq_pulse_q[2];

    //-----------------------------
    // Read-back, storage order
    //-----------------------------
    always_comb begin
        bus.rd_data = '0;
        case (bus.addr)
            REG_CTRL:       bus.rd_data[INIT_RST_BIT] = init_rst_o;
            REG_DMA_CMD: begin
                bus.rd_data[DMA_START_BIT] = mwr_start_o;
                bus.rd_data[DMA_DONE_BIT]  = mwr_done_q;
            end
            REG_MWR_ADDR:   bus.rd_data = mwr_addr_o;
            REG_MWR_COUNT:  bus.rd_data = mwr_count_o;
            REG_MWR_DATA:   bus.rd_data = mwr_data_o;
            REG_ACQ_TIME:   bus.rd_data = acq_time_o;
            REG_ACQ_COUNT:  bus.rd_data = acq_count_o;
            REG_ACQ_PARAM0: bus.rd_data = acq_param_dw0_o;
            REG_ACQ_PARAM1: bus.rd_data = acq_param_dw1_o;
            REG_ACQ_CTRL:   bus.rd_data[1:0] = stop_mode_o;  // Triggers read zero
            REG_LIST_CNT:   bus.rd_data = listdata_cnt_i;
            REG_LINK_STAT:  bus.rd_data[LINK_ON_BIT] = link_on_i;
            default: ;
        endcase
    end

    // Commits are at least three cycles apart, so pulses never stretch
    a_pulse_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        (acq_pulse_q != 3'b000) |=> (acq_pulse_q == 3'b000)
    );

endmodule

// File: rtl/ep_mem_access.sv
//-----------------------------
// Endpoint memory access top level
// Byte-lane write controller in front of
// the DMA and acquisition register file
//-----------------------------

`timescale 1ns/1ps

module ep_mem_access import ep_mem_pkg::*, ep_regmap_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // Register access
    input  reg_addr_t  addr_i,
    input  be_t        rd_be_i,
    input  be_t        wr_be_i,
    input  dword_t     wr_data_i,
    input  logic       wr_en_i,
    output dword_t     rd_data_o,
    output logic       wr_busy_o,
    // Status inputs
    input  logic       mwr_done_i,
    input  logic       link_on_i,
    input  dword_t     listdata_cnt_i,
    // Control outputs
    output logic       init_rst_o,
    output logic       mwr_start_o,
    output dword_t     mwr_addr_o,
    output dword_t     mwr_count_o,
    output dword_t     mwr_data_o,
    output dword_t     acq_time_o,
    output dword_t     acq_count_o,
    output dword_t     acq_param_dw0_o,
    output dword_t     acq_param_dw1_o,
    output stop_mode_t stop_mode_o,
    output logic       acq_start_o,
    output logic       acq_stop_o,
    output logic       acq_init_o
);

    reg_bus_if bus_if ();

    mem_rmw_ctrl u_rmw_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr_i    (addr_i),
        .rd_be_i   (rd_be_i),
        .wr_be_i   (wr_be_i),
        .wr_data_i (wr_data_i),
        .wr_en_i   (wr_en_i),
        .rd_data_o (rd_data_o),
        .wr_busy_o (wr_busy_o),
        .bus       (bus_if.ctrl)
    );

    ep_ctrl_regs u_ctrl_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus             (bus_if.regs),
        .mwr_done_i      (mwr_done_i),
        .link_on_i       (link_on_i),
        .listdata_cnt_i  (listdata_cnt_i),
        .init_rst_o      (init_rst_o),
        .mwr_start_o     (mwr_start_o),
        .mwr_addr_o      (mwr_addr_o),
        .mwr_count_o     (mwr_count_o),
        .mwr_data_o      (mwr_data_o),
        .acq_time_o      (acq_time_o),
        .acq_count_o     (acq_count_o),
        .acq_param_dw0_o (acq_param_dw0_o),
        .acq_param_dw1_o (acq_param_dw1_o),
        .stop_mode_o     (stop_mode_o),
        .acq_start_o     (acq_start_o),
        .acq_stop_o      (acq_stop_o),
        .acq_init_o      (acq_init_o)
    );

endmodule

// File: include/ep_tb_model.svh
//-----------------------------
// Register model for the testbench
// Swizzle, merge, read mask and
// per-register commit rules
//-----------------------------

`ifndef EP_TB_MODEL_SVH
`define EP_TB_MODEL_SVH

// Payload order and storage order are byte reversals of each other
function automatic dword_t swizzle_bytes(dword_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// Enabled lanes from the payload and the rest from the stored word
function automatic dword_t merge_lanes(dword_t old_word, dword_t payload, be_t be);
    dword_t pay_st;
    dword_t res;
    pay_st = swizzle_bytes(payload);
    for (int i = 0; i < NUM_LANES; i++) begin
        res[8*i +: 8] = be[i] ? pay_st[8*i +: 8] : old_word[8*i +: 8];
    end
    return res;
endfunction

// Stored word to payload order with disabled lanes zeroed
function automatic dword_t mask_read_lanes(dword_t stored, be_t be);
    dword_t masked;
    for (int i = 0; i < NUM_LANES; i++) begin
        masked[8*i +: 8] = be[i] ? stored[8*i +: 8] : 8'h00;
    end
    return swizzle_bytes(masked);
endfunction

// New stored word after a commit
// Status and unmapped indices keep their value
function automatic dword_t commit_word(reg_addr_t idx, dword_t old_word, dword_t merged);
    dword_t res;
    res = old_word;
    case (idx)
        REG_CTRL:     res = {31'b0, merged[INIT_RST_BIT]};
        REG_DMA_CMD: begin
            res[DMA_START_BIT] = merged[DMA_START_BIT];
            if (merged[DMA_START_BIT]) begin
                res[DMA_DONE_BIT] = 1'b0;
            end
        end
        REG_ACQ_CTRL: res = {30'b0, merged[1:0]};
        REG_MWR_ADDR, REG_MWR_COUNT, REG_MWR_DATA,
        REG_ACQ_TIME, REG_ACQ_COUNT, REG_ACQ_PARAM0, REG_ACQ_PARAM1: res = merged;
        default: ;
    endcase
    return res;
endfunction

// Expected pulses {init, stop, start} after a commit
function automatic logic [2:0] expected_pulses(reg_addr_t idx, dword_t merged);
    if (idx != REG_ACQ_CTRL) begin
        return 3'b000;
    end
    return {merged[ACQ_INIT_BIT], merged[ACQ_STOP_BIT], merged[ACQ_START_BIT]};
endfunction

`endif

// File: verification/tb_ep_mem_access.sv
//-----------------------------
// Testbench for the endpoint memory access block
// Random register traffic checked against a model
//-----------------------------

`timescale 1ns/1ps

module tb_ep_mem_access import ep_mem_pkg::*, ep_regmap_pkg::*; ();

    `include "ep_tb_model.svh"

    localparam realtime CLK_PERIOD = 100ns;
    localparam int RST_CYCLES = 8;
    localparam int N_PARTIAL  = 200;
    localparam int N_MASK     = 100;
    localparam int N_ACQ      = 20;
    localparam int N_RO       = 20;
    localparam int NUM_OPS    = 17 + 2*N_PARTIAL + N_MASK + 4 + 8 + 3*N_ACQ + 6*N_RO;

    logic clk = 1'b0;
    logic rst_n;
    reg_addr_t addr_i;
    be_t rd_be_i, wr_be_i;
    dword_t wr_data_i, listdata_cnt_i, rd_data_o;
    logic wr_en_i, mwr_done_i, link_on_i, wr_busy_o;
    logic init_rst_o, mwr_start_o, acq_start_o, acq_stop_o, acq_init_o;
    dword_t mwr_addr_o, mwr_count_o, mwr_data_o, acq_time_o, acq_count_o;
    dword_t acq_param_dw0_o, acq_param_dw1_o;
    stop_mode_t stop_mode_o;

    integer seed = 28871;
    int     errors = 0;
    dword_t model [12];                             // Storage order

    always #(CLK_PERIOD/2) clk = ~clk;

    ep_mem_access ep_mem_access_inst (.*);

    function automatic dword_t model_word(reg_addr_t a);
        return (a < 7'd12) ? model[a] : 32'h0;
    endfunction

    function automatic int pick(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic check_word(string name, dword_t exp, dword_t act);
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_outputs(string name);
        check_word({name, " init_rst"}, {31'b0, model[0][0]}, {31'b0, init_rst_o});
        check_word({name, " mwr_start"}, {31'b0, model[1][0]}, {31'b0, mwr_start_o});
        check_word({name, " mwr_addr"}, model[2], mwr_addr_o);
        check_word({name, " mwr_count"}, model[3], mwr_count_o);
        check_word({name, " mwr_data"}, model[4], mwr_data_o);
        check_word({name, " acq_time"}, model[5], acq_time_o);
        check_word({name, " acq_count"}, model[6], acq_count_o);
        check_word({name, " acq_param0"}, model[7], acq_param_dw0_o);
        check_word({name, " acq_param1"}, model[8], acq_param_dw1_o);
        check_word({name, " stop_mode"}, {30'b0, model[9][1:0]}, {30'b0, stop_mode_o});
    endtask

    task automatic read_check(string name, reg_addr_t a, be_t be);
        addr_i  = a;
        rd_be_i = be;
        @(posedge clk);
        #1;
        check_word(name, mask_read_lanes(model_word(a), be), rd_data_o);
    endtask

    // Issue one write, wait for the commit and check the trigger pulses
    task automatic write_reg(reg_addr_t a, dword_t data, be_t be);
        dword_t old_w;
        dword_t merged;
        logic [2:0] trig;
        old_w  = model_word(a);
        merged = merge_lanes(old_w, data, be);
        trig   = expected_pulses(a, merged);
        if (a < 7'd12) model[a] = commit_word(a, old_w, merged);
        addr_i    = a;
        wr_data_i = data;
        wr_be_i   = be;
        wr_en_i   = 1'b1;
        @(posedge clk);
        #1 wr_en_i = 1'b0;
        while (wr_busy_o) begin
            @(posedge clk);
            #1;
        end
        check_word("acq_pulse", {29'b0, trig}, {29'b0, acq_init_o, acq_stop_o, acq_start_o});
        @(posedge clk);
        #1;
        check_word("acq_pulse_end", 32'h0, {29'b0, acq_init_o, acq_stop_o, acq_start_o});
    endtask

    // Watchdog
    initial begin
        #((NUM_OPS * 6 + RST_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired, the DUT stopped responding");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        dword_t r;
        reg_addr_t a;
        reg_addr_t u;
        rst_n = 1'b0;
        {addr_i, rd_be_i, wr_be_i, wr_data_i, wr_en_i} = '0;
        {mwr_done_i, link_on_i, listdata_cnt_i} = '0;
        foreach (model[i]) model[i] = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        // ------------------------------
        check_outputs("reset");
        check_word("reset busy", 32'h0, {31'b0, wr_busy_o});
        check_word("reset pulses", 32'h0, {29'b0, acq_init_o, acq_stop_o, acq_start_o});
        for (int i = 0; i < 16; i++) read_check("reset read", reg_addr_t'(i), 4'hF);

        // ------------------------------
        for (int n = 0; n < N_PARTIAL; n++) begin
            a = reg_addr_t'(pick(2, 8));
            write_reg(a, dword_t'($random(seed)), be_t'($random(seed)));
            read_check("partial read", a, 4'hF);
            check_outputs("partial");
        end
        for (int n = 0; n < N_MASK; n++) begin
            read_check("masked read", reg_addr_t'(pick(0, 15)), be_t'($random(seed)));
        end

        // ------------------------------
        write_reg(REG_CTRL, 32'h0100_0000, 4'b0001);     // Raise initiator reset
        check_outputs("init reset set");
        read_check("init reset read", REG_CTRL, 4'hF);
        write_reg(REG_CTRL, 32'h0000_0000, 4'b0001);
        check_outputs("init reset clear");

        // ------------------------------
        write_reg(REG_DMA_CMD, 32'h0100_0000, 4'b0001);  // Payload byte 0, bit 0
        check_outputs("dma start");
        mwr_done_i = 1'b1;
        @(posedge clk);
        #1 mwr_done_i = 1'b0;
        model[1][DMA_START_BIT] = 1'b0;
        model[1][DMA_DONE_BIT]  = 1'b1;
        check_outputs("dma done");
        read_check("dma done flag", REG_DMA_CMD, 4'hF);
        write_reg(REG_DMA_CMD, 32'h0100_0000, 4'b0001);
        check_outputs("dma restart");
        read_check("dma done cleared", REG_DMA_CMD, 4'hF);

        // ------------------------------
        for (int n = 0; n < N_ACQ; n++) begin
            write_reg(REG_ACQ_CTRL, dword_t'($random(seed)), be_t'($random(seed)));
            check_outputs("acq ctrl");
            read_check("acq ctrl read", REG_ACQ_CTRL, 4'hF);
        end

        // ------------------------------
        for (int n = 0; n < N_RO; n++) begin
            r = dword_t'($random(seed));
            listdata_cnt_i = dword_t'($random(seed));
            link_on_i      = r[0];
            model[10] = listdata_cnt_i;
            model[11] = {31'b0, r[0]};
            read_check("list count", REG_LIST_CNT, 4'hF);
            read_check("link status", REG_LINK_STAT, 4'hF);
            a = reg_addr_t'(pick(10, 11));
            write_reg(a, dword_t'($random(seed)), 4'hF);
            u = reg_addr_t'(pick(12, 127));
            write_reg(u, dword_t'($random(seed)), 4'hF);
            check_outputs("read only");
            read_check("status after write", a, 4'hF);
            read_check("unmapped read", u, 4'hF);
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/ep_mem_pkg.sv
rtl/ep_regmap_pkg.sv
rtl/reg_bus_if.sv
rtl/mem_rmw_ctrl.sv
rtl/ep_ctrl_regs.sv
rtl/ep_mem_access.sv
verification/tb_ep_mem_access.sv

// File: Makefile
# Verilator flow for the endpoint memory access block

VERILATOR ?= verilator
FLIST     ?= vlog.f
TB_TOP    ?= tb_ep_mem_access
RTL_TOP   ?= ep_mem_access
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
